// File: rtl/morse_pkg.sv
package morse_pkg;

        // top-level parameter defaults
        parameter int MAX_CODE_LEN_DEF = 5;
        parameter int QUEUE_DEPTH_DEF  = 8;
        parameter int INIT_CREDITS_DEF = 4;

        // one input symbol per clock cycle
        typedef enum logic [2:0] {
                SYM_NONE  = 3'd0,
                SYM_DOT   = 3'd1,
                SYM_DASH  = 3'd2,
                SYM_END   = 3'd3,
                SYM_SPACE = 3'd4
        } sym_t;

        // ascii character
        typedef logic [7:0] char_t;

        // collected code bits
        // dot is 0, dash is 1, first symbol sits in bit 0
        typedef logic [MAX_CODE_LEN_DEF-1:0] code_t;

        // number of symbols collected so far
        typedef logic [2:0] len_t;

        // walker states
        typedef enum logic [1:0] {
                W_IDLE    = 2'd0,
                W_COLLECT = 2'd1,
                W_INVALID = 2'd2
        } walk_state_t;

        // emitted for a word space between letters
        parameter char_t CHAR_SPACE = 8'h20;

endpackage

// File: rtl/morse_lookup.sv
module morse_lookup #(
        parameter int MAX_CODE_LEN = morse_pkg::MAX_CODE_LEN_DEF
) (
        input  morse_pkg::code_t code,
        input  morse_pkg::len_t  len,
        output morse_pkg::char_t ch,
        output logic             hit
);

        import morse_pkg::*;

        localparam int KEY_W = $bits(len_t) + $bits(code_t);

        code_t            masked;
        logic [KEY_W-1:0] key;
        logic             found;

        always_comb begin
                // bits above the current length are not part of the code
                for (int i = 0; i < $bits(code_t); i++) begin
                        masked[i] = code[i] & (i < int'(len));
                end
                key   = {len, masked};
                ch    = '0;
                found = 1'b1;
                // code literals read last symbol first
                case (key)
                        {3'd1, 5'b00000}: ch = "E";
                        {3'd1, 5'b00001}: ch = "T";
                        {3'd2, 5'b00010}: ch = "A";
                        {3'd2, 5'b00000}: ch = "I";
                        {3'd2, 5'b00011}: ch = "M";
                        {3'd2, 5'b00001}: ch = "N";
                        {3'd3, 5'b00001}: ch = "D";
                        {3'd3, 5'b00011}: ch = "G";
                        {3'd3, 5'b00101}: ch = "K";
                        {3'd3, 5'b00111}: ch = "O";
                        {3'd3, 5'b00010}: ch = "R";
                        {3'd3, 5'b00000}: ch = "S";
                        {3'd3, 5'b00100}: ch = "U";
                        {3'd3, 5'b00110}: ch = "W";
                        {3'd4, 5'b00001}: ch = "B";
                        {3'd4, 5'b00101}: ch = "C";
                        {3'd4, 5'b00100}: ch = "F";
                        {3'd4, 5'b00000}: ch = "H";
                        {3'd4, 5'b01110}: ch = "J";
                        {3'd4, 5'b00010}: ch = "L";
                        {3'd4, 5'b00110}: ch = "P";
                        {3'd4, 5'b01011}: ch = "Q";
                        {3'd4, 5'b01000}: ch = "V";
                        {3'd4, 5'b01001}: ch = "X";
                        {3'd4, 5'b01101}: ch = "Y";
                        {3'd4, 5'b00011}: ch = "Z";
                        // digits are all five symbols long
                        {3'd5, 5'b11111}: ch = "0";
                        {3'd5, 5'b11110}: ch = "1";
                        {3'd5, 5'b11100}: ch = "2";
                        {3'd5, 5'b11000}: ch = "3";
                        {3'd5, 5'b10000}: ch = "4";
                        {3'd5, 5'b00000}: ch = "5";
                        {3'd5, 5'b00001}: ch = "6";
                        {3'd5, 5'b00011}: ch = "7";
                        {3'd5, 5'b00111}: ch = "8";
                        {3'd5, 5'b01111}: ch = "9";
                        default: found = 1'b0;
                endcase
        end

        // codes beyond the configured length never match
        assign hit = found && (int'(len) <= MAX_CODE_LEN);

endmodule

// File: rtl/morse_walker.sv
module morse_walker #(
        parameter int MAX_CODE_LEN = morse_pkg::MAX_CODE_LEN_DEF
) (
        input  logic             clk,
        input  logic             rst,
        input  morse_pkg::sym_t  sym,
        output logic             push,
        output morse_pkg::char_t push_char
);

        import morse_pkg::*;

        walk_state_t state_q;
        walk_state_t state_d;
        code_t       code_q;
        code_t       code_d;
        len_t        len_q;
        len_t        len_d;
        logic        push_d;
        char_t       char_d;
        char_t       lookup_ch;
        logic        lookup_hit;
        logic        sym_bit;

        morse_lookup #(
                .MAX_CODE_LEN(MAX_CODE_LEN)
        ) i_morse_lookup (
                .code(code_q),
                .len (len_q),
                .ch  (lookup_ch),
                .hit (lookup_hit)
        );

        // dash shifts in a one
        assign sym_bit = (sym == SYM_DASH);

        always_comb begin
                state_d = state_q;
                code_d  = code_q;
                len_d   = len_q;
                push_d  = 1'b0;
                char_d  = lookup_ch;
                case (state_q)
                        W_IDLE: begin
                                case (sym)
                                        SYM_DOT, SYM_DASH: begin
                                                state_d   = W_COLLECT;
                                                code_d    = '0;
                                                code_d[0] = sym_bit;
                                                len_d     = 3'd1;
                                        end
                                        SYM_SPACE: begin
                                                push_d = 1'b1;
                                                char_d = CHAR_SPACE;
                                        end
                                        default: ;
                                endcase
                        end
                        W_COLLECT: begin
                                case (sym)
                                        SYM_DOT, SYM_DASH: begin
                                                if (int'(len_q) >= MAX_CODE_LEN) begin
                                                        state_d = W_INVALID;
                                                end else begin
                                                        code_d[len_q] = sym_bit;
                                                        len_d         = len_q + 3'd1;
                                                end
                                        end
                                        SYM_END: begin
                                                // unknown patterns vanish silently
                                                push_d  = lookup_hit;
                                                state_d = W_IDLE;
                                                len_d   = '0;
                                        end
                                        SYM_SPACE: begin
                                                state_d = W_IDLE;
                                                len_d   = '0;
                                        end
                                        default: ;
                                endcase
                        end
                        W_INVALID: begin
                                // wait for the letter to close and emit nothing
                                if (sym == SYM_END || sym == SYM_SPACE) begin
                                        state_d = W_IDLE;
                                        len_d   = '0;
                                end
                        end
                        default: begin
                                state_d = W_IDLE;
                                len_d   = '0;
                        end
                endcase
        end

        always_ff @(posedge clk or negedge rst) begin
                if (!rst) begin
                        state_q <= W_IDLE;
                        code_q  <= '0;
                        len_q   <= '0;
                        push    <= 1'b0;
                end else begin
                        state_q <= state_d;
                        code_q  <= code_d;
                        len_q   <= len_d;
                        push    <= push_d;
                end
        end

        always_ff @(posedge clk) begin
                push_char <= char_d;
        end

endmodule

// File: rtl/char_queue.sv
module char_queue #(
        parameter int QUEUE_DEPTH = morse_pkg::QUEUE_DEPTH_DEF
) (
        input  logic             clk,
        input  logic             rst,
        input  logic             push,
        input  morse_pkg::char_t push_char,
        input  logic             pop,
        output logic             not_empty,
        output morse_pkg::char_t head_char,
        output logic             overrun
);

        import morse_pkg::*;

        localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
        localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

        char_t            mem [QUEUE_DEPTH];
        logic [PTR_W-1:0] wr_ptr;
        logic [PTR_W-1:0] rd_ptr;
        logic [CNT_W-1:0] count;
        logic             full;
        logic             do_push;
        logic             do_pop;

        assign full      = (count == CNT_W'(QUEUE_DEPTH));
        assign not_empty = (count != '0);
        assign head_char = mem[rd_ptr];

        assign do_pop  = pop && not_empty;
        // a pop in the same cycle frees the slot for the push
        assign do_push = push && (!full || do_pop);

        always_ff @(posedge clk or negedge rst) begin
                if (!rst) begin
                        wr_ptr  <= '0;
                        rd_ptr  <= '0;
                        count   <= '0;
                        overrun <= 1'b0;
                end else begin
                        if (do_push) begin
                                if (wr_ptr == PTR_W'(QUEUE_DEPTH - 1))
                                        wr_ptr <= '0;
                                else
                                        wr_ptr <= wr_ptr + 1'b1;
                        end
                        if (do_pop) begin
                                if (rd_ptr == PTR_W'(QUEUE_DEPTH - 1))
                                        rd_ptr <= '0;
                                else
                                        rd_ptr <= rd_ptr + 1'b1;
                        end
                        if (do_push && !do_pop)
                                count <= count + 1'b1;
                        else if (do_pop && !do_push)
                                count <= count - 1'b1;
                        // sticky until reset
                        if (push && !do_push)
                                overrun <= 1'b1;
                end
        end

        always_ff @(posedge clk) begin
                if (do_push)
                        mem[wr_ptr] <= push_char;
        end

endmodule

// File: rtl/credit_counter.sv
module credit_counter #(
        parameter int INIT_CREDITS = morse_pkg::INIT_CREDITS_DEF
) (
        input  logic clk,
        input  logic rst,
        input  logic credit_return,
        input  logic send,
        output logic have_credit
);

        // sized to hold the full initial credit
        localparam int CNT_W = $clog2(INIT_CREDITS + 1);

        logic [CNT_W-1:0] credits;

        assign have_credit = (credits != '0);

        always_ff @(posedge clk or negedge rst) begin
                if (!rst) begin
                        credits <= CNT_W'(INIT_CREDITS);
                end else begin
                        case ({credit_return, send})
                                2'b10: credits <= credits + 1'b1;
                                2'b01: credits <= credits - 1'b1;
                                // return and send cancel out
                                default: credits <= credits;
                        endcase
                end
        end

endmodule

// File: rtl/morse_decoder.sv
module morse_decoder #(
        parameter int MAX_CODE_LEN = morse_pkg::MAX_CODE_LEN_DEF,
        parameter int QUEUE_DEPTH  = morse_pkg::QUEUE_DEPTH_DEF,
        parameter int INIT_CREDITS = morse_pkg::INIT_CREDITS_DEF
) (
        input  logic             clk,
        input  logic             rst,
        input  morse_pkg::sym_t  sym,
        input  logic             credit_return,
        output logic             out_valid,
        output morse_pkg::char_t out_char,
        output logic             overrun
);

        import morse_pkg::*;

        logic  push;
        char_t push_char;
        logic  not_empty;
        char_t head_char;
        logic  have_credit;

        morse_walker #(
                .MAX_CODE_LEN(MAX_CODE_LEN)
        ) i_morse_walker (
                .clk      (clk),
                .rst      (rst),
                .sym      (sym),
                .push     (push),
                .push_char(push_char)
        );

        char_queue #(
                .QUEUE_DEPTH(QUEUE_DEPTH)
        ) i_char_queue (
                .clk      (clk),
                .rst      (rst),
                .push     (push),
                .push_char(push_char),
                .pop      (out_valid),
                .not_empty(not_empty),
                .head_char(head_char),
                .overrun  (overrun)
        );

        credit_counter #(
                .INIT_CREDITS(INIT_CREDITS)
        ) i_credit_counter (
                .clk          (clk),
                .rst          (rst),
                .credit_return(credit_return),
                .send         (out_valid),
                .have_credit  (have_credit)
        );

        // a character leaves only when the sink has room for it
        assign out_valid = not_empty && have_credit;
        assign out_char  = head_char;

endmodule

// File: verif/morse_decoder_sva.sv
module morse_decoder_sva #(
        parameter int INIT_CREDITS = morse_pkg::INIT_CREDITS_DEF
) (
        input logic             clk,
        input logic             rst,
        input logic             credit_return,
        input logic             out_valid,
        input morse_pkg::char_t out_char,
        input logic             overrun
);

        timeunit 1ns;
        timeprecision 100ps;

        int avail;
        int credit_fails;
        int reset_fails;
        int sticky_fails;
        int char_fails;
        int fail_count;

        assign fail_count = credit_fails + reset_fails + sticky_fails + char_fails;

        // credits granted to the DUT and not yet spent
        always_ff @(posedge clk or negedge rst) begin
                if (!rst)
                        avail <= INIT_CREDITS;
                else
                        avail <= avail + int'(credit_return) - int'(out_valid);
        end

        credit_check: assert property (
                @(posedge clk) disable iff (!rst) out_valid |-> avail > 0
        ) else begin
                $error("out_valid high with every credit spent");
                credit_fails++;
        end

        reset_check: assert property (
                @(posedge clk) $rose(rst) |-> !out_valid && !overrun
        ) else begin
                $error("out_valid or overrun high right after reset");
                reset_fails++;
        end

        sticky_check: assert property (
                @(posedge clk) disable iff (!rst) !$fell(overrun)
        ) else begin
                $error("overrun cleared without a reset");
                sticky_fails++;
        end

        // upper-case letter, digit or space
        char_check: assert property (
                @(posedge clk) disable iff (!rst)
                out_valid |-> (out_char inside {[8'h41:8'h5a], [8'h30:8'h39], 8'h20})
        ) else begin
                $error("out_char is not a legal character");
                char_fails++;
        end

endmodule

bind morse_decoder morse_decoder_sva #(.INIT_CREDITS(INIT_CREDITS)) i_morse_decoder_sva (.*);

// File: verif/tb_morse_decoder.sv
module tb_morse_decoder;

        timeunit 1ns;
        timeprecision 100ps;

        import morse_pkg::*;

        localparam int SEED = 32'hc47a_27a9;
        // five symbols with gaps plus the end symbol
        localparam int LETTER_CYCLES = 24;
        // credit returns and the quiet tail of one test
        localparam int DRAIN_CYCLES = 150;
        localparam int NUM_LETTERS = 64;
        localparam int TIMEOUT_CYCLES = 2 * (NUM_LETTERS * LETTER_CYCLES + 5 * DRAIN_CYCLES);

        logic  clk;
        logic  rst;
        sym_t  sym;
        logic  credit_return;
        logic  out_valid;
        char_t out_char;
        logic  overrun;
        logic  hold;
        char_t exp_q [$];
        int    seed, sink_seed, cycles;
        int    received, returned, exp_rd;
        int    mon_errors, seq_errors;
        int    tests_passed, tests_failed;

        string alphabet = "ABCDEFGHIJKLMNOPQRSTUVWXYZ0123456789";
        string code_tab [36] = '{
                ".-", "-...", "-.-.", "-..", ".", "..-.", "--.", "....", "..",
                ".---", "-.-", ".-..", "--", "-.", "---", ".--.", "--.-", ".-.",
                "...", "-", "..-", "...-", ".--", "-..-", "-.--", "--..",
                "-----", ".----", "..---", "...--", "....-",
                ".....", "-....", "--...", "---..", "----."
        };

        morse_decoder i_morse_decoder (
                .clk          (clk),
                .rst          (rst),
                .sym          (sym),
                .credit_return(credit_return),
                .out_valid    (out_valid),
                .out_char     (out_char),
                .overrun      (overrun)
        );

        initial begin
                clk = 1'b0;
                forever #5 clk = ~clk;
        end

        // sink model samples each character in the middle of its cycle
        initial begin
                credit_return = 1'b0;
                sink_seed     = ~SEED;
                forever begin
                        @(negedge clk);
                        // one credit back per character after a random delay
                        credit_return = 1'b0;
                        if (!hold && returned < received && ($random(sink_seed) & 3) == 0) begin
                                credit_return = 1'b1;
                                returned++;
                        end
                        // the DUT hands the character over on the next rising edge
                        if (rst && out_valid && exp_rd >= exp_q.size()) begin
                                $display("unexpected character %h on out_char at %0t ns",
                                         out_char, $time);
                                mon_errors++;
                                received++;
                        end else if (rst && out_valid) begin
                                assert (out_char == exp_q[exp_rd]) else begin
                                        $display("Fail at %0t ns: out_char expected %h, got %h",
                                                 $time, exp_q[exp_rd], out_char);
                                        mon_errors++;
                                end
                                exp_rd++;
                                received++;
                        end
                end
        end

        // stop at twice the worst case of all tests
        initial begin
                cycles = 0;
                while (cycles < TIMEOUT_CYCLES) begin
                        @(posedge clk);
                        cycles++;
                end
                $display("timeout after %0d cycles, the DUT stopped delivering", cycles);
                $display("SOME TESTS FAILED");
                $finish;
        end

        task automatic send_sym(input sym_t s);
                @(negedge clk);
                sym = s;
                @(negedge clk);
                sym = SYM_NONE;
        endtask

        task automatic send_code(input string code);
                int gap;
                for (int i = 0; i < code.len(); i++) begin
                        send_sym(code[i] == "-" ? SYM_DASH : SYM_DOT);
                        gap = $unsigned($random(seed)) % 3;
                        repeat (gap) @(negedge clk);
                end
                send_sym(SYM_END);
        endtask

        task automatic send_letter(input int idx, input bit expect_out);
                if (expect_out)
                        exp_q.push_back(char_t'(alphabet[idx]));
                send_code(code_tab[idx]);
        endtask

        task automatic wait_drained();
                while (exp_rd < exp_q.size() || returned != received)
                        @(negedge clk);
                // a stray character would show up during this quiet tail
                repeat (10) @(negedge clk);
        endtask

        function automatic int err_total();
                return mon_errors + seq_errors +
                       i_morse_decoder.i_morse_decoder_sva.fail_count;
        endfunction

        task automatic end_test(input int num, input string name, input int errs_before);
                int errs;
                errs = err_total() - errs_before;
                if (errs == 0)
                        tests_passed++;
                else
                        tests_failed++;
                $display("test %0d %s: %0d errors", num, name, errs);
        endtask

        initial begin
                int mark;
                int base;
                int idx;

                rst  = 1'b0;
                sym  = SYM_NONE;
                hold = 1'b0;
                seed = SEED;
                repeat (5) @(negedge clk);
                rst = 1'b1;
                repeat (2) @(negedge clk);

                mark = err_total();
                for (int i = 0; i < 36; i++)
                        send_letter(i, 1'b1);
                wait_drained();
                end_test(1, "letters and digits", mark);

                mark = err_total();
                exp_q.push_back(CHAR_SPACE);
                send_sym(SYM_SPACE);
                // space in the middle of a code drops it
                send_sym(SYM_DOT);
                send_sym(SYM_DASH);
                send_sym(SYM_SPACE);
                send_letter(10, 1'b1);
                wait_drained();
                end_test(2, "word space", mark);

                mark = err_total();
                send_code("..--");
                send_code("......");
                send_sym(SYM_END);
                send_letter(4, 1'b1);
                wait_drained();
                end_test(3, "invalid codes", mark);

                // sink keeps its credits so only the first few get out
                mark = err_total();
                base = received;
                hold = 1'b1;
                for (int i = 0; i < 6; i++) begin
                        idx = $unsigned($random(seed)) % 36;
                        send_letter(idx, 1'b1);
                end
                repeat (20) @(negedge clk);
                assert (received - base == INIT_CREDITS_DEF) else begin
                        $display("Fail at %0t ns: out_valid count expected %0d, got %0d",
                                 $time, INIT_CREDITS_DEF, received - base);
                        seq_errors++;
                end
                hold = 1'b0;
                wait_drained();
                assert (!overrun) else begin
                        $display("Fail at %0t ns: overrun expected 0, got %b", $time, overrun);
                        seq_errors++;
                end
                end_test(4, "credit hold", mark);

                // the last two letters find the queue full
                mark = err_total();
                hold = 1'b1;
                for (int i = 0; i < QUEUE_DEPTH_DEF + INIT_CREDITS_DEF + 2; i++) begin
                        idx = $unsigned($random(seed)) % 36;
                        send_letter(idx, i < QUEUE_DEPTH_DEF + INIT_CREDITS_DEF);
                end
                repeat (5) @(negedge clk);
                assert (overrun) else begin
                        $display("Fail at %0t ns: overrun expected 1, got %b", $time, overrun);
                        seq_errors++;
                end
                hold = 1'b0;
                wait_drained();
                end_test(5, "queue overrun", mark);

                $display("tests run 5, passed %0d, failed %0d, errors %0d",
                         tests_passed, tests_failed, err_total());
                if (err_total() == 0)
                        $display("ALL TESTS PASSED");
                else
                        $display("SOME TESTS FAILED");
                $finish;
        end

endmodule

// File: morse_decoder.f
rtl/morse_pkg.sv
rtl/morse_lookup.sv
rtl/morse_walker.sv
rtl/char_queue.sv
rtl/credit_counter.sv
rtl/morse_decoder.sv
verif/morse_decoder_sva.sv
verif/tb_morse_decoder.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the morse decoder testbench with verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_morse_decoder
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
        --top-module "$TOP" -Mdir obj_dir -f morse_decoder.f
status=$?
if [ $status -ne 0 ]; then
        echo "compile failed with status $status"
        exit 1
fi

./obj_dir/V"$TOP" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
        echo "simulation exited with status $status"
        exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
        exit 1
fi
exit 0
